/* source/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit import decode_pkg::*; (
	input  logic            clk,
	input  logic            arst_n_i,
	input  logic [XLEN-1:0] pc_i,
	input  logic [XLEN-1:0] inst_i,
	input  logic [XLEN-1:0] reg1_i,
	input  logic [XLEN-1:0] reg2_i,
	input  alu_op_e         aluop_i,
	input  logic            stall_i,
	output branch_t         branch_o,
	output logic [XLEN-1:0] link_addr_o
);

	logic [XLEN-1:0] b_imm;
	logic [XLEN-1:0] j_imm;
	logic [XLEN-1:0] i_imm;
	logic [XLEN-1:0] jalr_sum;
	logic            eq;
	logic            lt_s;
	logic            lt_u;
	logic            take;
	logic [XLEN-1:0] target;

	assign b_imm = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
	assign j_imm = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
	assign i_imm = {{20{inst_i[31]}}, inst_i[31:20]};

	assign jalr_sum = reg1_i + i_imm;

	assign eq   = (reg1_i == reg2_i);
	assign lt_s = ($signed(reg1_i) < $signed(reg2_i));
	assign lt_u = (reg1_i < reg2_i);

	always_comb begin
		take   = 1'b0;
		target = '0;
		case (aluop_i)
			ALU_BEQ:  take = eq;
			ALU_BNE:  take = !eq;
			ALU_BLT:  take = lt_s;
			ALU_BGE:  take = !lt_s;
			ALU_BLTU: take = lt_u;
			ALU_BGEU: take = !lt_u;
			ALU_JAL: begin
				take   = 1'b1;
				target = pc_i + j_imm;
			end
			ALU_JALR: begin
				take   = 1'b1;
				target = {jalr_sum[XLEN-1:1], 1'b0}; // lsb cleared
			end
			default: take = 1'b0;
		endcase
		if (aluop_i inside {ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU})
			target = pc_i + b_imm;
	end

	// no redirect while operands are not trustworthy
	assign branch_o.taken  = take && !stall_i;
	assign branch_o.target = target;

	assign link_addr_o = (aluop_i == ALU_JAL || aluop_i == ALU_JALR) ? pc_i + 32'd4 : '0;

	// a link address goes with a redirect unless stalled
	a_link_with_jump: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		(link_addr_o != '0) |-> (branch_o.taken || stall_i)
	);

endmodule

/* source/decode_pkg.sv */
package decode_pkg;

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;

	// major opcodes
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;

	// funct3 of the alu group, same for reg-imm and reg-reg forms
	localparam logic [2:0] F3_ADD  = 3'b000; // also SUB
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101; // SRL / SRA by funct7
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	localparam logic [2:0] F3_LB   = 3'b000;
	localparam logic [2:0] F3_LH   = 3'b001;
	localparam logic [2:0] F3_LW   = 3'b010;
	localparam logic [2:0] F3_LBU  = 3'b100;
	localparam logic [2:0] F3_LHU  = 3'b101;

	localparam logic [2:0] F3_SB   = 3'b000;
	localparam logic [2:0] F3_SH   = 3'b001;
	localparam logic [2:0] F3_SW   = 3'b010;

	localparam logic [2:0] F3_JALR = 3'b000;

	localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
	localparam logic [6:0] FUNCT7_ALT  = 7'b0100000; // SUB, SRA, SRAI

	typedef enum logic [4:0] {
		ALU_NOP, ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
		ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
		ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
		ALU_JAL, ALU_JALR,
		ALU_LB, ALU_LH, ALU_LW, ALU_LBU, ALU_LHU,
		ALU_SB, ALU_SH, ALU_SW
	} alu_op_e;

	typedef enum logic [2:0] {
		RES_NOP, RES_LOGIC, RES_SHIFT, RES_ARITH, RES_JUMP_BRANCH, RES_LOAD_STORE
	} alu_sel_e;

	// write-back of a later stage
	typedef struct packed {
		logic                  we;
		logic [REG_ADDR_W-1:0] waddr;
		logic [XLEN-1:0]       wdata;
	} fwd_src_t;

	typedef struct packed {
		alu_op_e               aluop;
		alu_sel_e              alusel;
		logic [REG_ADDR_W-1:0] waddr;
		logic                  we;
		logic                  re1;
		logic                  re2;
		logic [XLEN-1:0]       imm;
		logic                  valid;
	} decoded_t;

	typedef struct packed {
		logic            taken;
		logic [XLEN-1:0] target;
	} branch_t;

	typedef struct packed {
		alu_op_e               aluop;
		alu_sel_e              alusel;
		logic [XLEN-1:0]       reg1;
		logic [XLEN-1:0]       reg2;
		logic [REG_ADDR_W-1:0] waddr;
		logic                  we;
		logic [XLEN-1:0]       link_addr;
		logic [XLEN-1:0]       inst;
	} id_ex_t;

endpackage

/* source/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import decode_pkg::*; (
	input  logic                  clk,
	input  logic                  arst_n_i,
	input  logic [XLEN-1:0]       pc_i,
	input  logic [XLEN-1:0]       inst_i,

	// write-backs from execute and memory
	input  fwd_src_t              ex_fwd_i,
	input  fwd_src_t              mem_fwd_i,
	input  alu_op_e               ex_aluop_i,

	// register file, two read ports
	input  logic [XLEN-1:0]       rf_rdata1_i,
	input  logic [XLEN-1:0]       rf_rdata2_i,
	output logic [REG_ADDR_W-1:0] rf_raddr1_o,
	output logic [REG_ADDR_W-1:0] rf_raddr2_o,
	output logic                  rf_re1_o,
	output logic                  rf_re2_o,

	output logic                  stall_o,
	output branch_t               branch_o,
	output id_ex_t                id_ex_o
);

	decoded_t        dec;
	logic [XLEN-1:0] reg1;
	logic [XLEN-1:0] reg2;
	logic [XLEN-1:0] link_addr;
	logic            stall_rs1;
	logic            stall_rs2;

	inst_decoder u_decoder (
		.inst_i   (inst_i),
		.dec_o    (dec),
		.raddr1_o (rf_raddr1_o),
		.raddr2_o (rf_raddr2_o)
	);

	assign rf_re1_o = dec.re1;
	assign rf_re2_o = dec.re2;

	operand_forward u_fwd_rs1 (
		.read_en_i    (dec.re1),
		.raddr_i      (rf_raddr1_o),
		.imm_i        (dec.imm),
		.rf_data_i    (rf_rdata1_i),
		.ex_fwd_i     (ex_fwd_i),
		.mem_fwd_i    (mem_fwd_i),
		.ex_aluop_i   (ex_aluop_i),
		.operand_o    (reg1),
		.load_stall_o (stall_rs1)
	);

	operand_forward u_fwd_rs2 (
		.read_en_i    (dec.re2),
		.raddr_i      (rf_raddr2_o),
		.imm_i        (dec.imm),
		.rf_data_i    (rf_rdata2_i),
		.ex_fwd_i     (ex_fwd_i),
		.mem_fwd_i    (mem_fwd_i),
		.ex_aluop_i   (ex_aluop_i),
		.operand_o    (reg2),
		.load_stall_o (stall_rs2)
	);

	assign stall_o = stall_rs1 | stall_rs2; // load-use on either source

	branch_unit u_branch (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.pc_i        (pc_i),
		.inst_i      (inst_i),
		.reg1_i      (reg1),
		.reg2_i      (reg2),
		.aluop_i     (dec.aluop),
		.stall_i     (stall_o),
		.branch_o    (branch_o),
		.link_addr_o (link_addr)
	);

	id_ex_reg u_id_ex (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.stall_i     (stall_o),
		.dec_i       (dec),
		.reg1_i      (reg1),
		.reg2_i      (reg2),
		.link_addr_i (link_addr),
		.inst_i      (inst_i),
		.id_ex_o     (id_ex_o)
	);

endmodule

/* source/id_ex_reg.sv */
`timescale 1ns/1ps

module id_ex_reg import decode_pkg::*; (
	input  logic            clk,
	input  logic            arst_n_i,
	input  logic            stall_i,
	input  decoded_t        dec_i,
	input  logic [XLEN-1:0] reg1_i,
	input  logic [XLEN-1:0] reg2_i,
	input  logic [XLEN-1:0] link_addr_i,
	input  logic [XLEN-1:0] inst_i,
	output id_ex_t          id_ex_o
);

	alu_op_e               aluop_q;
	alu_sel_e              alusel_q;
	logic [REG_ADDR_W-1:0] waddr_q;
	logic                  we_q;
	logic [XLEN-1:0]       reg1_q;
	logic [XLEN-1:0]       reg2_q;
	logic [XLEN-1:0]       link_addr_q;
	logic [XLEN-1:0]       inst_q;

	// control fields, bubble on reset or stall
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			aluop_q  <= ALU_NOP;
			alusel_q <= RES_NOP;
			waddr_q  <= '0;
			we_q     <= 1'b0;
		end else if (stall_i) begin
			aluop_q  <= ALU_NOP;
			alusel_q <= RES_NOP;
			waddr_q  <= '0;
			we_q     <= 1'b0;
		end else begin
			aluop_q  <= dec_i.aluop;
			alusel_q <= dec_i.alusel;
			waddr_q  <= dec_i.waddr;
			we_q     <= dec_i.we;
		end
	end

	always_ff @(posedge clk) begin
		reg1_q      <= reg1_i;
		reg2_q      <= reg2_i;
		link_addr_q <= link_addr_i;
		inst_q      <= inst_i;
	end

	assign id_ex_o.aluop     = aluop_q;
	assign id_ex_o.alusel    = alusel_q;
	assign id_ex_o.reg1      = reg1_q;
	assign id_ex_o.reg2      = reg2_q;
	assign id_ex_o.waddr     = waddr_q;
	assign id_ex_o.we        = we_q;
	assign id_ex_o.link_addr = link_addr_q;
	assign id_ex_o.inst      = inst_q;

	// a write-back always belongs to a real op
	a_we_has_op: assert property (
		@(posedge clk) disable iff (!arst_n_i) id_ex_o.we |-> id_ex_o.aluop != ALU_NOP
	);

endmodule

/* source/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder import decode_pkg::*; (
	input  logic [XLEN-1:0]       inst_i,
	output decoded_t              dec_o,
	output logic [REG_ADDR_W-1:0] raddr1_o,
	output logic [REG_ADDR_W-1:0] raddr2_o
);

	logic [6:0]            opcode;
	logic [2:0]            funct3;
	logic [6:0]            funct7;
	logic [REG_ADDR_W-1:0] rd;
	logic [XLEN-1:0]       i_imm;
	logic [XLEN-1:0]       shamt;
	logic [XLEN-1:0]       u_imm;

	alu_op_e         base_op; // alu op from funct3 alone
	alu_op_e         op;
	alu_sel_e        sel;
	logic            valid;
	logic            we;
	logic            re1;
	logic            re2;
	logic            lui_x0;
	logic [XLEN-1:0] imm;

	assign opcode = inst_i[6:0];
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];
	assign rd     = inst_i[11:7];

	assign i_imm = {{20{inst_i[31]}}, inst_i[31:20]};
	assign shamt = {27'b0, inst_i[24:20]};
	assign u_imm = {inst_i[31:12], 12'b0};

	always_comb begin
		case (funct3)
			F3_ADD:  base_op = ALU_ADD;
			F3_SLL:  base_op = ALU_SLL;
			F3_SLT:  base_op = ALU_SLT;
			F3_SLTU: base_op = ALU_SLTU;
			F3_XOR:  base_op = ALU_XOR;
			F3_SR:   base_op = ALU_SRL;
			F3_OR:   base_op = ALU_OR;
			default: base_op = ALU_AND;
		endcase
	end

	always_comb begin
		op     = ALU_NOP;
		valid  = 1'b0;
		we     = 1'b0;
		re1    = 1'b0;
		re2    = 1'b0;
		lui_x0 = 1'b0;
		imm    = '0;
		case (opcode)
			OPC_OP_IMM: begin
				we    = 1'b1;
				re1   = 1'b1;
				imm   = i_imm;
				op    = base_op;
				valid = 1'b1;
				if (funct3 == F3_SLL) begin
					imm   = shamt;
					valid = (funct7 == FUNCT7_BASE);
				end else if (funct3 == F3_SR) begin
					imm   = shamt;
					op    = (funct7 == FUNCT7_ALT) ? ALU_SRA : ALU_SRL;
					valid = (funct7 == FUNCT7_BASE) || (funct7 == FUNCT7_ALT);
				end
			end
			OPC_OP: begin
				we    = 1'b1;
				re1   = 1'b1;
				re2   = 1'b1;
				op    = base_op;
				valid = (funct7 == FUNCT7_BASE); // M-extension funct7 falls out here
				if (funct7 == FUNCT7_ALT) begin
					valid = (funct3 == F3_ADD) || (funct3 == F3_SR);
					op    = (funct3 == F3_ADD) ? ALU_SUB : ALU_SRA;
				end
			end
			OPC_BRANCH: begin
				re1   = 1'b1;
				re2   = 1'b1;
				valid = 1'b1;
				case (funct3)
					F3_BEQ:  op = ALU_BEQ;
					F3_BNE:  op = ALU_BNE;
					F3_BLT:  op = ALU_BLT;
					F3_BGE:  op = ALU_BGE;
					F3_BLTU: op = ALU_BLTU;
					F3_BGEU: op = ALU_BGEU;
					default: valid = 1'b0;
				endcase
			end
			OPC_LOAD: begin
				we    = 1'b1;
				re1   = 1'b1;
				imm   = i_imm;   // offset rides on operand 2
				valid = 1'b1;
				case (funct3)
					F3_LB:   op = ALU_LB;
					F3_LH:   op = ALU_LH;
					F3_LW:   op = ALU_LW;
					F3_LBU:  op = ALU_LBU;
					F3_LHU:  op = ALU_LHU;
					default: valid = 1'b0; // LD, LWU and the rest
				endcase
			end
			OPC_STORE: begin
				re1   = 1'b1;
				re2   = 1'b1;
				valid = 1'b1;
				case (funct3)
					F3_SB:   op = ALU_SB;
					F3_SH:   op = ALU_SH;
					F3_SW:   op = ALU_SW;
					default: valid = 1'b0;
				endcase
			end
			OPC_LUI: begin
				we     = 1'b1;
				re1    = 1'b1;
				lui_x0 = 1'b1; // x0 | imm
				imm    = u_imm;
				op     = ALU_OR;
				valid  = 1'b1;
			end
			OPC_JAL: begin
				we    = 1'b1;
				op    = ALU_JAL;
				valid = 1'b1;
			end
			OPC_JALR: begin
				we    = 1'b1;
				re1   = 1'b1;
				imm   = i_imm;
				op    = ALU_JALR;
				valid = (funct3 == F3_JALR);
			end
			default: valid = 1'b0;
		endcase
	end

	// result class follows from the op
	always_comb begin
		case (op)
			ALU_AND, ALU_OR, ALU_XOR:              sel = RES_LOGIC;
			ALU_SLL, ALU_SRL, ALU_SRA:             sel = RES_SHIFT;
			ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU:   sel = RES_ARITH;
			ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE,
			ALU_BLTU, ALU_BGEU, ALU_JAL, ALU_JALR: sel = RES_JUMP_BRANCH;
			ALU_LB, ALU_LH, ALU_LW, ALU_LBU,
			ALU_LHU, ALU_SB, ALU_SH, ALU_SW:       sel = RES_LOAD_STORE;
			default:                               sel = RES_NOP;
		endcase
	end

	assign dec_o.valid  = valid;
	assign dec_o.aluop  = valid ? op : ALU_NOP;
	assign dec_o.alusel = valid ? sel : RES_NOP;
	assign dec_o.we     = valid & we;
	assign dec_o.re1    = valid & re1;
	assign dec_o.re2    = valid & re2;
	assign dec_o.waddr  = (valid & we) ? rd : '0;
	assign dec_o.imm    = imm;

	assign raddr1_o = lui_x0 ? '0 : inst_i[19:15];
	assign raddr2_o = inst_i[24:20];

	// every accepted encoding names a real op and result class
	always_comb begin
		a_valid_has_op: assert final (!dec_o.valid ||
			(dec_o.aluop != ALU_NOP && dec_o.alusel != RES_NOP));
	end

endmodule

/* source/operand_forward.sv */
`timescale 1ns/1ps

module operand_forward import decode_pkg::*; (
	input  logic                  read_en_i,
	input  logic [REG_ADDR_W-1:0] raddr_i,
	input  logic [XLEN-1:0]       imm_i,
	input  logic [XLEN-1:0]       rf_data_i,
	input  fwd_src_t              ex_fwd_i,
	input  fwd_src_t              mem_fwd_i,
	input  alu_op_e               ex_aluop_i,
	output logic [XLEN-1:0]       operand_o,
	output logic                  load_stall_o
);

	logic not_x0;
	logic ex_match;
	logic ex_is_load;
	logic ex_hit;
	logic mem_hit;

	assign not_x0   = (raddr_i != '0); // x0 is never forwarded
	assign ex_match = not_x0 && (ex_fwd_i.waddr == raddr_i);

	assign ex_is_load = ex_aluop_i inside {ALU_LB, ALU_LH, ALU_LW, ALU_LBU, ALU_LHU};

	assign ex_hit  = ex_fwd_i.we && ex_match;
	assign mem_hit = mem_fwd_i.we && not_x0 && (mem_fwd_i.waddr == raddr_i);

	// load data is not ready until after mem
	assign load_stall_o = ex_is_load && read_en_i && ex_match;

	always_comb begin
		if (!read_en_i)
			operand_o = imm_i;
		else if (ex_hit)
			operand_o = ex_fwd_i.wdata;   // youngest wins
		else if (mem_hit)
			operand_o = mem_fwd_i.wdata;
		else
			operand_o = rf_data_i;
	end

endmodule

/* tests/decode_stage_tb.sv */
`timescale 1ns/1ps

module decode_stage_tb import decode_pkg::*; ();

	localparam int NUM_VECTORS = 2000;
	localparam int CLK_PERIOD  = 100;

	logic                  clk;
	logic                  arst_n;
	logic [XLEN-1:0]       pc;
	logic [XLEN-1:0]       inst;
	fwd_src_t              ex_fwd;
	fwd_src_t              mem_fwd;
	alu_op_e               ex_aluop;
	logic [XLEN-1:0]       rf_rdata1;
	logic [XLEN-1:0]       rf_rdata2;
	logic [REG_ADDR_W-1:0] rf_raddr1;
	logic [REG_ADDR_W-1:0] rf_raddr2;
	logic                  rf_re1;
	logic                  rf_re2;
	logic                  stall;
	branch_t               branch;
	id_ex_t                id_ex;

	logic [XLEN-1:0] rf_mem [32]; // register file model
	int              errors = 0;
	int              cycle = 0;

	// reference results for the instruction now on the inputs
	alu_op_e               exp_op;
	logic                  exp_we;
	logic                  exp_re1;
	logic                  exp_re2;
	logic                  exp_stall;
	logic                  exp_taken;
	logic [REG_ADDR_W-1:0] exp_a1;
	logic [REG_ADDR_W-1:0] exp_a2;
	logic [XLEN-1:0]       exp_imm;
	logic [XLEN-1:0]       exp_op1;
	logic [XLEN-1:0]       exp_op2;
	logic [XLEN-1:0]       exp_target;
	id_ex_t                exp_next;
	id_ex_t                exp_q;      // what id_ex should hold now
	logic                  chk_q = 1'b0;
	logic                  full_q = 1'b0; // previous cycle was a real instruction

	decode_stage uut (
		.clk         (clk),
		.arst_n_i    (arst_n),
		.pc_i        (pc),
		.inst_i      (inst),
		.ex_fwd_i    (ex_fwd),
		.mem_fwd_i   (mem_fwd),
		.ex_aluop_i  (ex_aluop),
		.rf_rdata1_i (rf_rdata1),
		.rf_rdata2_i (rf_rdata2),
		.rf_raddr1_o (rf_raddr1),
		.rf_raddr2_o (rf_raddr2),
		.rf_re1_o    (rf_re1),
		.rf_re2_o    (rf_re2),
		.stall_o     (stall),
		.branch_o    (branch),
		.id_ex_o     (id_ex)
	);

	assign rf_rdata1 = rf_mem[rf_raddr1];
	assign rf_rdata2 = rf_mem[rf_raddr2];

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic alu_op_e expect_op(input logic [XLEN-1:0] in);
		logic [16:0] key;
		key = {in[31:25], in[14:12], in[6:0]}; // funct7, funct3, opcode
		casez (key)
			17'b???????_000_0010011, 17'b0000000_000_0110011: return ALU_ADD;
			17'b0100000_000_0110011:                          return ALU_SUB;
			17'b???????_010_0010011, 17'b0000000_010_0110011: return ALU_SLT;
			17'b???????_011_0010011, 17'b0000000_011_0110011: return ALU_SLTU;
			17'b???????_100_0010011, 17'b0000000_100_0110011: return ALU_XOR;
			17'b???????_110_0010011, 17'b0000000_110_0110011,
			17'b???????_???_0110111:                          return ALU_OR; // lui is x0 | imm
			17'b???????_111_0010011, 17'b0000000_111_0110011: return ALU_AND;
			17'b0000000_001_0?10011:                          return ALU_SLL;
			17'b0000000_101_0?10011:                          return ALU_SRL;
			17'b0100000_101_0?10011:                          return ALU_SRA;
			17'b???????_000_1100011: return ALU_BEQ;
			17'b???????_001_1100011: return ALU_BNE;
			17'b???????_100_1100011: return ALU_BLT;
			17'b???????_101_1100011: return ALU_BGE;
			17'b???????_110_1100011: return ALU_BLTU;
			17'b???????_111_1100011: return ALU_BGEU;
			17'b???????_???_1101111: return ALU_JAL;
			17'b???????_000_1100111: return ALU_JALR;
			17'b???????_000_0000011: return ALU_LB;
			17'b???????_001_0000011: return ALU_LH;
			17'b???????_010_0000011: return ALU_LW;
			17'b???????_100_0000011: return ALU_LBU;
			17'b???????_101_0000011: return ALU_LHU;
			17'b???????_000_0100011: return ALU_SB;
			17'b???????_001_0100011: return ALU_SH;
			17'b???????_010_0100011: return ALU_SW;
			default:                 return ALU_NOP; // unsupported
		endcase
	endfunction

	// result class of each kept operation
	function automatic alu_sel_e result_class(input alu_op_e op);
		case (op)
			ALU_AND, ALU_OR, ALU_XOR:            return RES_LOGIC;
			ALU_SLL, ALU_SRL, ALU_SRA:           return RES_SHIFT;
			ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU: return RES_ARITH;
			ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE,
			ALU_BLTU, ALU_BGEU, ALU_JAL, ALU_JALR:
				return RES_JUMP_BRANCH;
			ALU_LB, ALU_LH, ALU_LW, ALU_LBU,
			ALU_LHU, ALU_SB, ALU_SH, ALU_SW:
				return RES_LOAD_STORE;
			default:                             return RES_NOP;
		endcase
	endfunction

	function automatic logic [XLEN-1:0] select_operand(input logic re,
			input logic [REG_ADDR_W-1:0] addr, input logic [XLEN-1:0] imm,
			input logic [XLEN-1:0] rf_val, input fwd_src_t ex, input fwd_src_t mem);
		if (!re)
			return imm;
		if (addr != '0 && ex.we && ex.waddr == addr)
			return ex.wdata;
		if (addr != '0 && mem.we && mem.waddr == addr)
			return mem.wdata;
		return rf_val;
	endfunction

	function automatic logic [XLEN-1:0] random_inst();
		logic [XLEN-1:0] r;
		r = $urandom;
		case ($urandom_range(0, 9))
			0, 1: begin
				r[6:0] = OPC_OP_IMM;
				if (r[13:12] == 2'b01) // slli / srli / srai
					r[31:25] = ($urandom_range(0, 3) == 0) ? FUNCT7_ALT : FUNCT7_BASE;
			end
			2: begin
				r[6:0] = OPC_OP;
				case ($urandom_range(0, 5))
					0:       r[31:25] = FUNCT7_ALT;
					1:       r[31:25] = 7'b0000001; // M extension, must be rejected
					default: r[31:25] = FUNCT7_BASE;
				endcase
			end
			3: r[6:0] = OPC_LUI;
			4: begin
				r[6:0] = OPC_BRANCH;
				if ($urandom_range(0, 1) == 1)
					r[24:20] = r[19:15]; // equal operands
			end
			5: r[6:0] = OPC_JAL;
			6: begin
				r[6:0]   = OPC_JALR;
				r[14:12] = F3_JALR;
			end
			7: r[6:0] = OPC_LOAD;
			8: begin
				r[6:0]   = OPC_STORE;
				r[14:12] = 3'($urandom_range(0, 3));
			end
			default: ; // raw word, mostly invalid
		endcase
		return r;
	endfunction

	function automatic fwd_src_t random_fwd(input logic [XLEN-1:0] in);
		fwd_src_t f;
		f.we    = ($urandom_range(0, 3) != 0);
		f.wdata = $urandom;
		case ($urandom_range(0, 3))
			0:       f.waddr = in[19:15];
			1:       f.waddr = in[24:20];
			2:       f.waddr = '0;
			default: f.waddr = REG_ADDR_W'($urandom);
		endcase
		return f;
	endfunction

	task automatic report_error(input string name, input logic [XLEN-1:0] got,
			input logic [XLEN-1:0] exp);
		errors++;
		$display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
	endtask

	always_comb begin
		logic [6:0]      opc;
		logic [XLEN-1:0] i_imm;
		logic [XLEN-1:0] b_imm;
		logic [XLEN-1:0] j_imm;
		logic            ex_load;
		logic            cond;
		opc   = inst[6:0];
		i_imm = {{20{inst[31]}}, inst[31:20]};
		b_imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
		j_imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

		exp_op  = expect_op(inst);
		exp_we  = (exp_op != ALU_NOP) && !(opc inside {OPC_BRANCH, OPC_STORE});
		exp_re1 = (exp_op != ALU_NOP) && (opc != OPC_JAL);
		exp_re2 = (exp_op != ALU_NOP) && (opc inside {OPC_OP, OPC_BRANCH, OPC_STORE});
		exp_a1  = (opc == OPC_LUI) ? '0 : inst[19:15];
		exp_a2  = inst[24:20];

		if (opc == OPC_LUI)
			exp_imm = {inst[31:12], 12'h000};
		else if (opc == OPC_OP_IMM && inst[13:12] == 2'b01)
			exp_imm = {27'd0, inst[24:20]}; // shift amount
		else if (opc inside {OPC_OP_IMM, OPC_LOAD, OPC_JALR})
			exp_imm = i_imm;
		else
			exp_imm = '0;

		exp_op1 = select_operand(exp_re1, exp_a1, exp_imm, rf_mem[exp_a1], ex_fwd, mem_fwd);
		exp_op2 = select_operand(exp_re2, exp_a2, exp_imm, rf_mem[exp_a2], ex_fwd, mem_fwd);

		ex_load   = ex_aluop inside {ALU_LB, ALU_LH, ALU_LW, ALU_LBU, ALU_LHU};
		exp_stall = ex_load && ((exp_re1 && exp_a1 != '0 && ex_fwd.waddr == exp_a1) ||
			(exp_re2 && exp_a2 != '0 && ex_fwd.waddr == exp_a2));

		case (exp_op)
			ALU_BEQ:           cond = (exp_op1 == exp_op2);
			ALU_BNE:           cond = (exp_op1 != exp_op2);
			ALU_BLT:           cond = ($signed(exp_op1) < $signed(exp_op2));
			ALU_BGE:           cond = ($signed(exp_op1) >= $signed(exp_op2));
			ALU_BLTU:          cond = (exp_op1 < exp_op2);
			ALU_BGEU:          cond = (exp_op1 >= exp_op2);
			ALU_JAL, ALU_JALR: cond = 1'b1;
			default:           cond = 1'b0;
		endcase
		exp_taken = cond && !exp_stall;
		if (exp_op == ALU_JAL)
			exp_target = pc + j_imm;
		else if (exp_op == ALU_JALR)
			exp_target = (exp_op1 + i_imm) & ~32'd1;
		else
			exp_target = pc + b_imm;

		exp_next.aluop     = exp_stall ? ALU_NOP : exp_op;
		exp_next.alusel    = exp_stall ? RES_NOP : result_class(exp_op);
		exp_next.reg1      = exp_op1;
		exp_next.reg2      = exp_op2;
		exp_next.we        = exp_we && !exp_stall;
		exp_next.waddr     = exp_next.we ? inst[11:7] : '0;
		exp_next.link_addr = (exp_op inside {ALU_JAL, ALU_JALR}) ? pc + 32'd4 : '0;
		exp_next.inst      = inst;
	end

	always @(posedge clk) begin
		exp_q  <= exp_next;
		chk_q  <= arst_n;
		full_q <= arst_n && (exp_op != ALU_NOP) && !exp_stall;
		cycle  <= cycle + 1;
	end

	// same-cycle outputs
	a_stall: assert property (@(posedge clk) disable iff (!arst_n) stall == exp_stall)
		else report_error("stall_o", $sampled(stall), $sampled(exp_stall));
	a_taken: assert property (@(posedge clk) disable iff (!arst_n) branch.taken == exp_taken)
		else report_error("branch_o.taken", $sampled(branch.taken), $sampled(exp_taken));
	a_target: assert property (@(posedge clk) disable iff (!arst_n)
		exp_taken |-> branch.target == exp_target)
		else report_error("branch_o.target", $sampled(branch.target), $sampled(exp_target));
	a_re: assert property (@(posedge clk) disable iff (!arst_n)
		{rf_re1, rf_re2} == {exp_re1, exp_re2})
		else report_error("rf_re", $sampled({rf_re1, rf_re2}), $sampled({exp_re1, exp_re2}));
	a_raddr1: assert property (@(posedge clk) disable iff (!arst_n)
		exp_re1 |-> rf_raddr1 == exp_a1)
		else report_error("rf_raddr1_o", $sampled(rf_raddr1), $sampled(exp_a1));
	a_raddr2: assert property (@(posedge clk) disable iff (!arst_n)
		exp_re2 |-> rf_raddr2 == exp_a2)
		else report_error("rf_raddr2_o", $sampled(rf_raddr2), $sampled(exp_a2));

	// id_ex one cycle later
	a_aluop: assert property (@(posedge clk) chk_q |-> id_ex.aluop == exp_q.aluop)
		else report_error("id_ex_o.aluop", $sampled(id_ex.aluop), $sampled(exp_q.aluop));
	a_alusel: assert property (@(posedge clk) chk_q |-> id_ex.alusel == exp_q.alusel)
		else report_error("id_ex_o.alusel", $sampled(id_ex.alusel), $sampled(exp_q.alusel));
	a_we: assert property (@(posedge clk) chk_q |-> id_ex.we == exp_q.we)
		else report_error("id_ex_o.we", $sampled(id_ex.we), $sampled(exp_q.we));
	a_waddr: assert property (@(posedge clk) chk_q |-> id_ex.waddr == exp_q.waddr)
		else report_error("id_ex_o.waddr", $sampled(id_ex.waddr), $sampled(exp_q.waddr));
	a_inst: assert property (@(posedge clk) chk_q |-> id_ex.inst == exp_q.inst)
		else report_error("id_ex_o.inst", $sampled(id_ex.inst), $sampled(exp_q.inst));
	a_reg1: assert property (@(posedge clk) full_q |-> id_ex.reg1 == exp_q.reg1)
		else report_error("id_ex_o.reg1", $sampled(id_ex.reg1), $sampled(exp_q.reg1));
	a_reg2: assert property (@(posedge clk) full_q |-> id_ex.reg2 == exp_q.reg2)
		else report_error("id_ex_o.reg2", $sampled(id_ex.reg2), $sampled(exp_q.reg2));
	a_link: assert property (@(posedge clk) full_q |-> id_ex.link_addr == exp_q.link_addr)
		else report_error("id_ex_o.link_addr", $sampled(id_ex.link_addr),
			$sampled(exp_q.link_addr));
	a_reset_bubble: assert property (@(posedge clk)
		(!arst_n && cycle > 0) |-> (id_ex.we == 1'b0 && id_ex.aluop == ALU_NOP))
		else report_error("id_ex_o.{aluop,we}", $sampled({id_ex.aluop, id_ex.we}),
			{ALU_NOP, 1'b0});

	initial begin
		logic [XLEN-1:0] next_inst;
		void'($urandom(37));
		arst_n   <= 1'b0;
		pc       <= '0;
		inst     <= '0;
		ex_fwd   <= '0;
		mem_fwd  <= '0;
		ex_aluop <= ALU_NOP;
		rf_mem[0] = '0; // x0 reads zero
		for (int i = 1; i < 32; i++)
			rf_mem[i] = $urandom;

		repeat (16) @(posedge clk);
		arst_n <= 1'b1;
		for (int n = 0; n < NUM_VECTORS; n++) begin
			if (!stall) begin
				next_inst = random_inst();
				pc        <= $urandom & 32'hffff_fffc;
			end else begin
				next_inst = inst; // fetch holds the word while stalled
			end
			inst    <= next_inst;
			ex_fwd  <= random_fwd(next_inst);
			mem_fwd <= random_fwd(next_inst);
			if ($urandom_range(0, 3) == 0)
				ex_aluop <= alu_op_e'(int'(ALU_LB) + $urandom_range(0, 4));
			else
				ex_aluop <= alu_op_e'($urandom_range(0, int'(ALU_JALR)));
			@(posedge clk);
		end
		@(posedge clk);
		#1;

		$display("vectors: %0d, errors: %0d", NUM_VECTORS, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// watchdog
	initial begin
		#((16 + NUM_VECTORS * 2) * CLK_PERIOD + 20 * CLK_PERIOD);
		$display("Timeout: the run did not finish in time, %0d errors so far", errors);
		$display("Checks failed");
		$finish;
	end

endmodule

/* vlog.f */
source/decode_pkg.sv
source/inst_decoder.sv
source/operand_forward.sv
source/branch_unit.sv
source/id_ex_reg.sv
source/decode_stage.sv
tests/decode_stage_tb.sv
